// File: all.f
+incdir+include
design/cpu_pkg.sv
design/register_bank.sv
design/ram.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/writeback.sv
design/cpu.sv
tb/cpu_tb.sv

// File: design/cpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu (
    input  logic             clock,
    input  logic             reset,
    input  logic             enable,
    input  logic [`XLEN-1:0] rom_data,
    output logic [`XLEN-1:0] rom_address,
    output cpu_pkg::retire_t retire,
    output logic [5:0]       led
);
    // Stage to stage
    cpu_pkg::if_de_t    if_de;
    cpu_pkg::de_ex_t    de_ex;
    cpu_pkg::ex_mem_t   ex_mem;
    cpu_pkg::mem_wb_t   mem_wb;
    cpu_pkg::redirect_t redirect;   // Execute back to fetch and decode

    // Register bank
    cpu_pkg::rb_write_t rb_write;
    logic [4:0]         rs1_address;
    logic [4:0]         rs2_address;
    logic [`XLEN-1:0]   rs1_value;
    logic [`XLEN-1:0]   rs2_value;

    // Data RAM
    logic [`XLEN-1:0]   ram_address;
    logic [`XLEN-1:0]   ram_write_data;
    logic               ram_write_enable;
    logic [`XLEN-1:0]   ram_read_data;

    fetch fetch_stage (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .redirect(redirect),
        .rom_data(rom_data),
        .rom_address(rom_address),
        .if_de(if_de)
    );

    decode decode_stage (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .if_de(if_de),
        .redirect(redirect),
        .rs1_address(rs1_address),
        .rs2_address(rs2_address),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .de_ex(de_ex)
    );

    execute execute_stage (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .de_ex(de_ex),
        .redirect(redirect),
        .ex_mem(ex_mem)
    );

    memory memory_stage (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .ex_mem(ex_mem),
        .ram_address(ram_address),
        .ram_write_data(ram_write_data),
        .ram_write_enable(ram_write_enable),
        .ram_read_data(ram_read_data),
        .mem_wb(mem_wb)
    );

    writeback writeback_stage (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .mem_wb(mem_wb),
        .rb_write(rb_write),
        .retire(retire),
        .led(led)
    );

    register_bank regs (
        .clock(clock),
        .reset(reset),
        .rb_write(rb_write),
        .rs1_address(rs1_address),
        .rs2_address(rs2_address),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value)
    );

    ram data_ram (
        .clock(clock),
        .address(ram_address),
        .write_data(ram_write_data),
        .write_enable(ram_write_enable),
        .read_data(ram_read_data)
    );

endmodule

// File: design/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b    // lui
    } alu_op_t;

    // Fetch to decode
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } if_de_t;

    // Decode to execute
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] rs1_value;
        logic [`XLEN-1:0] rs2_value;
        alu_op_t          alu_op;
        logic             alu_src_imm;
        logic             mem_read;
        logic             mem_write;
        logic             reg_write;
        logic [4:0]       rd;
        logic             branch;
        logic             branch_ne;   // bne when set, beq otherwise
    } de_ex_t;

    // Execute to memory
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] store_data;
        logic             mem_read;
        logic             mem_write;
        logic             reg_write;
        logic [4:0]       rd;
    } ex_mem_t;

    // Memory to writeback
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] load_data;
        logic             mem_to_reg;
        logic             reg_write;
        logic [4:0]       rd;
    } mem_wb_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic             enable;
        logic [4:0]       address;
        logic [`XLEN-1:0] value;
    } rb_write_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] value;
    } retire_t;

endpackage

// File: design/decode.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  cpu_pkg::if_de_t    if_de,
    input  cpu_pkg::redirect_t redirect,
    output logic [4:0]         rs1_address,
    output logic [4:0]         rs2_address,
    input  logic [`XLEN-1:0]   rs1_value,
    input  logic [`XLEN-1:0]   rs2_value,
    output cpu_pkg::de_ex_t    de_ex
);
    cpu_pkg::opcode_t  opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [`XLEN-1:0]  imm_i;
    logic [`XLEN-1:0]  imm_s;
    logic [`XLEN-1:0]  imm_b;
    logic [`XLEN-1:0]  imm_u;
    logic [`XLEN-1:0]  imm;
    cpu_pkg::alu_op_t  alu_op;
    logic              alu_src_imm;
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    logic              branch;
    logic              branch_ne;

    assign opcode = cpu_pkg::opcode_t'(if_de.instr[6:0]);
    assign funct3 = if_de.instr[14:12];
    assign funct7 = if_de.instr[31:25];
    assign rs1_address = if_de.instr[19:15];
    assign rs2_address = if_de.instr[24:20];

    assign imm_i = {{20{if_de.instr[31]}}, if_de.instr[31:20]};
    assign imm_s = {{20{if_de.instr[31]}}, if_de.instr[31:25], if_de.instr[11:7]};
    assign imm_b = {{19{if_de.instr[31]}}, if_de.instr[31], if_de.instr[7],
                    if_de.instr[30:25], if_de.instr[11:8], 1'b0};
    assign imm_u = {if_de.instr[31:12], 12'h000};

    always_comb begin
        // Anything unrecognised falls through as a nop
        imm = imm_i;
        alu_op = cpu_pkg::alu_add;
        alu_src_imm = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch = 1'b0;
        branch_ne = 1'b0;
        case (opcode)
            cpu_pkg::opc_op_imm: begin
                alu_src_imm = 1'b1;
                reg_write = (funct3 == 3'b000);   // addi only
            end
            cpu_pkg::opc_op: begin
                reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = cpu_pkg::alu_add;
                    {7'b0100000, 3'b000}: alu_op = cpu_pkg::alu_sub;
                    {7'b0000000, 3'b111}: alu_op = cpu_pkg::alu_and;
                    {7'b0000000, 3'b110}: alu_op = cpu_pkg::alu_or;
                    {7'b0000000, 3'b100}: alu_op = cpu_pkg::alu_xor;
                    {7'b0000000, 3'b010}: alu_op = cpu_pkg::alu_slt;
                    default: reg_write = 1'b0;
                endcase
            end
            cpu_pkg::opc_lui: begin
                imm = imm_u;
                alu_op = cpu_pkg::alu_pass_b;
                alu_src_imm = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::opc_load: begin
                alu_src_imm = 1'b1;
                mem_read = (funct3 == 3'b010);    // lw only
                reg_write = (funct3 == 3'b010);
            end
            cpu_pkg::opc_store: begin
                imm = imm_s;
                alu_src_imm = 1'b1;
                mem_write = (funct3 == 3'b010);   // sw only
            end
            cpu_pkg::opc_branch: begin
                imm = imm_b;
                branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                branch_ne = (funct3 == 3'b001);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            de_ex.valid <= 1'b0;
        end else if (enable) begin
            de_ex.valid <= if_de.valid && !redirect.taken;
            de_ex.pc <= if_de.pc;
            de_ex.imm <= imm;
            de_ex.rs1_value <= rs1_value;
            de_ex.rs2_value <= rs2_value;
            de_ex.alu_op <= alu_op;
            de_ex.alu_src_imm <= alu_src_imm;
            de_ex.mem_read <= mem_read;
            de_ex.mem_write <= mem_write;
            de_ex.reg_write <= reg_write;
            de_ex.rd <= if_de.instr[11:7];
            de_ex.branch <= branch;
            de_ex.branch_ne <= branch_ne;
        end
    end

endmodule

// File: design/execute.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  cpu_pkg::de_ex_t    de_ex,
    output cpu_pkg::redirect_t redirect,
    output cpu_pkg::ex_mem_t   ex_mem
);
    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] alu_result;
    logic             equal;

    assign operand_a = de_ex.rs1_value;
    assign operand_b = de_ex.alu_src_imm ? de_ex.imm : de_ex.rs2_value;

    always_comb begin
        case (de_ex.alu_op)
            cpu_pkg::alu_add:    alu_result = operand_a + operand_b;
            cpu_pkg::alu_sub:    alu_result = operand_a - operand_b;
            cpu_pkg::alu_and:    alu_result = operand_a & operand_b;
            cpu_pkg::alu_or:     alu_result = operand_a | operand_b;
            cpu_pkg::alu_xor:    alu_result = operand_a ^ operand_b;
            cpu_pkg::alu_slt:    alu_result = `XLEN'($signed(operand_a) < $signed(operand_b));
            cpu_pkg::alu_pass_b: alu_result = operand_b;
            default:             alu_result = '0;
        endcase
    end

    // Branch compare always uses the register operands
    assign equal = (de_ex.rs1_value == de_ex.rs2_value);

    assign redirect.taken = de_ex.valid && de_ex.branch && (equal != de_ex.branch_ne);
    assign redirect.target = de_ex.pc + de_ex.imm;

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else if (enable) begin
            ex_mem.valid <= de_ex.valid;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= de_ex.rs2_value;
            ex_mem.mem_read <= de_ex.mem_read;
            ex_mem.mem_write <= de_ex.mem_write;
            ex_mem.reg_write <= de_ex.reg_write;
            ex_mem.rd <= de_ex.rd;
        end
    end

    // The slot behind a taken branch reaches execute cancelled
    assert property (@(posedge clock) disable iff (reset)
        redirect.taken && enable |=> !de_ex.valid)
        else $error("execute: entry behind a taken branch was not cancelled");

endmodule

// File: design/fetch.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  cpu_pkg::redirect_t redirect,
    input  logic [`XLEN-1:0]   rom_data,
    output logic [`XLEN-1:0]   rom_address,
    output cpu_pkg::if_de_t    if_de
);
    logic [`XLEN-1:0] pc;

    assign rom_address = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `RESET_PC;
            if_de.valid <= 1'b0;
        end else if (enable) begin
            // Taken branch in execute wins over sequential fetch
            pc <= redirect.taken ? redirect.target : pc + `XLEN'(4);
            if_de.valid <= !redirect.taken;   // Squash the word fetched this cycle
            if_de.pc <= pc;
            if_de.instr <= rom_data;
        end
    end

    // Branch targets from execute must keep the PC word-aligned
    assert property (@(posedge clock) disable iff (reset)
        rom_address[1:0] == 2'b00)
        else $error("fetch: misaligned rom_address %h", rom_address);

endmodule

// File: design/memory.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module memory (
    input  logic             clock,
    input  logic             reset,
    input  logic             enable,
    input  cpu_pkg::ex_mem_t ex_mem,
    output logic [`XLEN-1:0] ram_address,
    output logic [`XLEN-1:0] ram_write_data,
    output logic             ram_write_enable,
    input  logic [`XLEN-1:0] ram_read_data,
    output cpu_pkg::mem_wb_t mem_wb
);
    assign ram_address = ex_mem.alu_result;
    assign ram_write_data = ex_mem.store_data;

    // Store lands at the edge ending this stage, held off while stalled
    assign ram_write_enable = enable && ex_mem.valid && ex_mem.mem_write;

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
        end else if (enable) begin
            mem_wb.valid <= ex_mem.valid;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data <= ram_read_data;
            mem_wb.mem_to_reg <= ex_mem.mem_read;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.rd <= ex_mem.rd;
        end
    end

    // Decode sets at most one of the two memory controls
    assert property (@(posedge clock) disable iff (reset)
        ex_mem.valid |-> !(ex_mem.mem_read && ex_mem.mem_write))
        else $error("memory: load and store on the same entry");

endmodule

// File: design/ram.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module ram (
    input  logic             clock,
    input  logic [`XLEN-1:0] address,
    input  logic [`XLEN-1:0] write_data,
    input  logic             write_enable,
    output logic [`XLEN-1:0] read_data
);
    localparam int index_bits = $clog2(`RAM_WORDS);

    logic [`XLEN-1:0]      words [`RAM_WORDS];
    logic [index_bits-1:0] index;

    // Word index, byte offset dropped
    assign index = address[index_bits+1:2];

    always_ff @(posedge clock) begin
        if (write_enable) begin
            words[index] <= write_data;
        end
    end

    assign read_data = words[index];   // Combinational read

endmodule

// File: design/register_bank.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_bank (
    input  logic               clock,
    input  logic               reset,
    input  cpu_pkg::rb_write_t rb_write,
    input  logic [4:0]         rs1_address,
    input  logic [4:0]         rs2_address,
    output logic [`XLEN-1:0]   rs1_value,
    output logic [`XLEN-1:0]   rs2_value
);
    logic [`XLEN-1:0] regs [32];
    logic             write_hit1;
    logic             write_hit2;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rb_write.enable && rb_write.address != 5'd0) begin
            regs[rb_write.address] <= rb_write.value;
        end
    end

    // Write-through covers the writeback/decode overlap
    assign write_hit1 = rb_write.enable && rb_write.address == rs1_address;
    assign write_hit2 = rb_write.enable && rb_write.address == rs2_address;

    assign rs1_value = (rs1_address == 5'd0) ? '0 : write_hit1 ? rb_write.value : regs[rs1_address];
    assign rs2_value = (rs2_address == 5'd0) ? '0 : write_hit2 ? rb_write.value : regs[rs2_address];

    // Writeback must never request a write to x0
    assert property (@(posedge clock) disable iff (reset)
        rb_write.enable |-> rb_write.address != 5'd0)
        else $error("register_bank: write request to x0");

endmodule

// File: design/writeback.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module writeback (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  cpu_pkg::mem_wb_t   mem_wb,
    output cpu_pkg::rb_write_t rb_write,
    output cpu_pkg::retire_t   retire,
    output logic [5:0]         led
);
    logic [`XLEN-1:0] result;
    logic             write;

    assign result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

    // No write while stalled so nothing retires twice
    assign write = enable && mem_wb.valid && mem_wb.reg_write && mem_wb.rd != 5'd0;

    assign rb_write.enable = write;
    assign rb_write.address = mem_wb.rd;
    assign rb_write.value = result;

    assign retire.valid = write;
    assign retire.rd = mem_wb.rd;
    assign retire.value = result;

    always_ff @(posedge clock) begin
        if (reset) begin
            led <= '0;
        end else if (write) begin
            led <= result[5:0];   // Last retired value
        end
    end

endmodule

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and address width, the core assumes 32
`define XLEN 32

// Data RAM depth in words, power of two
`define RAM_WORDS 256

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f all.f -o cpu_tb_sim

output=$(./obj_dir/cpu_tb_sim)
echo "$output"

if echo "$output" | grep -q "TB PASSED"; then
    exit 0
else
    exit 1
fi

// File: tb/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;
    localparam logic [31:0] nop = 32'h0000_0013;   // addi x0, x0, 0
    localparam int max_stall = 60;

    logic             clock;
    logic             reset;
    logic             enable;
    logic [`XLEN-1:0] rom_data;
    logic [`XLEN-1:0] rom_address;
    cpu_pkg::retire_t retire;
    logic [5:0]       led;

    logic [31:0] prog [256];
    int          prog_len;
    logic [4:0]  exp_rd [512];
    logic [31:0] exp_value [512];
    int          exp_count;
    int          section_end_word [4];
    int          test_end [4];
    string       test_name [4];
    int          retire_index;
    logic [5:0]  expected_led;
    logic        started;
    int          errors;
    int          stall_left;
    int          stall_cycles;
    real         limit_ns;
    logic [31:0] lfsr;

    cpu dut (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .rom_data(rom_data),
        .rom_address(rom_address),
        .retire(retire),
        .led(led)
    );

    always #4 clock = ~clock;

    // Program ROM answers nops past the end
    assign rom_data = (rom_address[31:2] < 30'(prog_len)) ? prog[rom_address[9:2]] : nop;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] i_format(logic [31:0] imm, int rs1, int f3, int rd,
                                             logic [6:0] op);
        return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] r_format(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] s_format(logic [31:0] imm, int rs2, int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_format(logic [31:0] imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_format(logic [31:0] imm, int rd);
        return {imm[19:0], 5'(rd), 7'h37};
    endfunction

    task automatic put(logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // Two nops keep every consumer three slots behind its producer
    task automatic emit(logic [31:0] word);
        put(word);
        put(nop);
        put(nop);
    endtask

    // Branch over two shadow writes to x31 onto the next slot
    task automatic branch(int rs1, int rs2, int f3, int mark);
        put(b_format(32'd12, rs2, rs1, f3));
        put(i_format(32'(mark), 0, 0, 31, 7'h13));
        put(i_format(32'(mark + 1), 0, 0, 31, 7'h13));
    endtask

    task automatic assemble_program();
        prog_len = 0;
        emit(i_format(random_bits(12), 0, 0, 1, 7'h13));
        emit(i_format(random_bits(12), 0, 0, 2, 7'h13));
        emit(r_format('h00, 2, 1, 0, 3));    // add
        emit(r_format('h20, 2, 1, 0, 4));    // sub
        emit(r_format('h00, 2, 1, 7, 5));    // and
        emit(r_format('h00, 2, 1, 6, 6));    // or
        emit(r_format('h00, 2, 1, 4, 7));    // xor
        emit(r_format('h00, 2, 1, 2, 8));    // slt
        emit(r_format('h00, 1, 2, 2, 9));
        emit(u_format(random_bits(20), 10));
        emit(i_format(random_bits(12), 10, 0, 11, 7'h13));
        section_end_word[0] = prog_len;
        emit(u_format(random_bits(20), 12));
        emit(i_format(random_bits(12), 12, 0, 12, 7'h13));
        emit(i_format(random_bits(7) << 2, 0, 0, 13, 7'h13));
        emit(s_format(32'd0, 12, 13));
        emit(s_format(32'd4, 1, 13));
        emit(i_format(32'd0, 13, 2, 14, 7'h03));   // lw
        emit(i_format(32'd4, 13, 2, 15, 7'h03));
        section_end_word[1] = prog_len;
        emit(i_format(32'd5, 0, 0, 16, 7'h13));
        emit(i_format(32'd6, 0, 0, 17, 7'h13));
        branch(16, 16, 0, 10);    // beq taken
        emit(i_format(32'd20, 0, 0, 20, 7'h13));
        branch(16, 17, 1, 12);    // bne taken
        emit(i_format(32'd21, 0, 0, 21, 7'h13));
        branch(16, 17, 0, 14);    // beq not taken
        emit(i_format(32'd22, 0, 0, 22, 7'h13));
        branch(16, 16, 1, 16);    // bne not taken
        emit(i_format(32'd23, 0, 0, 23, 7'h13));
        section_end_word[2] = prog_len;
        emit(i_format(random_bits(12), 0, 0, 0, 7'h13));
        emit(r_format('h00, 2, 1, 0, 0));
        emit(r_format('h00, 0, 0, 0, 18));
        emit(r_format('h00, 0, 1, 0, 19));
        section_end_word[3] = prog_len;
    endtask

    // Architectural model, run in program order
    task automatic predict_retires();
        logic [31:0] r [32];
        logic [31:0] mem [256];
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] value;
        logic        write;
        int          section;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) mem[i] = '0;
        exp_count = 0;
        pc = 0;
        for (int i = 0; i < 4; i++) test_end[i] = 0;
        while (pc[31:2] < 30'(prog_len)) begin
            instr = prog[pc[9:2]];
            a = r[instr[19:15]];
            b = r[instr[24:20]];
            imm_i = {{20{instr[31]}}, instr[31:20]};
            write = 1'b0;
            value = '0;
            case (instr[6:0])
                7'h13: begin
                    write = (instr[14:12] == 3'd0);
                    value = a + imm_i;
                end
                7'h33: begin
                    write = 1'b1;
                    case ({instr[31:25], instr[14:12]})
                        10'h000: value = a + b;
                        10'h100: value = a - b;
                        10'h007: value = a & b;
                        10'h006: value = a | b;
                        10'h004: value = a ^ b;
                        10'h002: value = {31'd0, $signed(a) < $signed(b)};
                        default: write = 1'b0;
                    endcase
                end
                7'h37: begin
                    write = 1'b1;
                    value = {instr[31:12], 12'h000};
                end
                7'h03: begin
                    write = (instr[14:12] == 3'd2);
                    value = mem[8'((a + imm_i) >> 2)];
                end
                7'h23: mem[8'((a + {{20{instr[31]}}, instr[31:25], instr[11:7]}) >> 2)] = b;
                7'h63: begin
                    if ((a == b) != instr[12]) begin
                        pc = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                   instr[11:8], 1'b0} - 4;
                    end
                end
                default: ;
            endcase
            if (write && instr[11:7] != 5'd0) begin
                r[instr[11:7]] = value;
                exp_rd[exp_count] = instr[11:7];
                exp_value[exp_count] = value;
                exp_count++;
                section = 0;
                while (section < 3 && pc[31:2] >= 30'(section_end_word[section])) section++;
                test_end[section] = exp_count;
            end
            pc = pc + 4;
        end
        for (int i = 1; i < 4; i++) begin
            if (test_end[i] < test_end[i-1]) test_end[i] = test_end[i-1];
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            retire_index <= 0;
            expected_led <= '0;
        end else if (retire.valid) begin
            retire_index <= retire_index + 1;
            expected_led <= exp_value[retire_index][5:0];
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        !started |-> (rom_address == `RESET_PC && !retire.valid))
        else begin
            errors++;
            $display("Fail at %0t ns: activity before the first enabled edge", $time);
        end

    assert property (@(posedge clock) disable iff (reset)
        retire.valid |-> (retire_index < exp_count && retire.rd == exp_rd[retire_index]
                          && retire.value == exp_value[retire_index]))
        else begin
            errors++;
            $display("Fail at %0t ns: retire x%0d = %h, expected x%0d = %h", $time,
                     $sampled(retire.rd), $sampled(retire.value),
                     exp_rd[$sampled(retire_index)], exp_value[$sampled(retire_index)]);
        end

    assert property (@(posedge clock) disable iff (reset) led == expected_led)
        else begin
            errors++;
            $display("Fail at %0t ns: led %h, expected %h", $time, $sampled(led),
                     $sampled(expected_led));
        end

    assert property (@(posedge clock) disable iff (reset) !enable |=> $stable(rom_address))
        else begin
            errors++;
            $display("Fail at %0t ns: rom_address moved during a stall", $time);
        end

    assert property (@(posedge clock) disable iff (reset) !enable |-> !retire.valid)
        else begin
            errors++;
            $display("Fail at %0t ns: retire during a stall", $time);
        end

    assert property (@(posedge clock) disable iff (reset) retire.valid |-> retire.rd != 5'd0)
        else begin
            errors++;
            $display("Fail at %0t ns: retire to x0", $time);
        end

    // Watchdog sized from the program length and the stall budget
    initial begin
        wait (limit_ns > 0.0);
        #(limit_ns);
        $display("Timeout: the program did not retire all instructions in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int section;
        int section_errors;
        clock = 1'b0;
        limit_ns = 0.0;
        errors = 0;
        stall_left = 0;
        stall_cycles = 0;
        section = 0;
        section_errors = 0;
        lfsr = 32'd82521;
        reset <= 1'b1;
        enable <= 1'b0;
        started <= 1'b0;
        test_name[0] = "alu chain";
        test_name[1] = "store and load";
        test_name[2] = "branches";
        test_name[3] = "x0 writes";
        assemble_program();
        predict_retires();
        limit_ns = real'((2 * prog_len + max_stall + 20) * 8);
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        repeat (3) @(posedge clock);
        $display("Test 1 reset: done, errors %0d", errors);
        section_errors = errors;
        enable <= 1'b1;
        started <= 1'b1;
        while (retire_index < exp_count) begin
            @(posedge clock);
            if (stall_left > 0) begin
                enable <= 1'b0;
                stall_left--;
                stall_cycles++;
            end else begin
                enable <= 1'b1;
                if (stall_cycles + 4 <= max_stall && random_bits(3) == 0) begin
                    stall_left = 1 + int'(random_bits(2));
                end
            end
            while (section < 4 && retire_index >= test_end[section]) begin
                $display("Test %0d %s: done, errors %0d", section < 3 ? section + 2 : 6,
                         test_name[section], errors - section_errors);
                section_errors = errors;
                section++;
            end
        end
        enable <= 1'b1;
        repeat (6) @(posedge clock);
        assert (stall_cycles > 0)
            else begin
                errors++;
                $display("The enable input was never held low, so no stall was exercised");
            end
        $display("Test 5 stalls: %0d stall cycles, errors %0d", stall_cycles, errors);
        $display("Summary: 6 tests, retired %0d of %0d, errors %0d", retire_index, exp_count,
                 errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
